/* tests/addrgen_stimulus.hex */
// mode _ st_pend _ lsu_hold _ addr _ len _ stride _ ctrl _ exp_err _ exp_count _ first_addr _ first_len
// mode 1 gives random ready lines; ctrl is vew[3:2] is_load[1] unit_stride[0]
0_00_00_00001002_0004_00000000_B_1_0000_00000000_00
0_00_00_00002014_0014_00000000_B_0_0001_00002014_0A
0_00_00_00003F80_0020_00000000_D_0_0002_00003F80_0F
0_00_00_00010000_04B0_00000000_5_0_0002_00010000_FF
0_00_00_00020C00_0C10_00000000_1_0_0003_00020C00_7F
0_00_00_00005004_0006_00000040_8_0_0006_00005004_00
1_10_00_00006000_0008_00000100_E_0_0008_00006000_00
1_00_00_00007FF0_0040_00000000_3_0_0002_00007FF0_01
1_00_00_0000B000_0005_FFFFFFFE_4_0_0005_0000B000_00
0_00_00_0000C006_0003_00000008_C_1_0000_00000000_00
0_00_50_00009000_0004_00000000_F_0_0001_00009000_03
0_00_00_0000A000_0004_00000000_D_0_0001_0000A000_03

/* tb.f */
src/vlsu_pkg.sv
src/axi_ax_pkg.sv
src/addrgen_ctrl.sv
src/burst_planner.sv
src/ax_issuer.sv
src/lsu_req_queue.sv
src/vlsu_addrgen.sv
tests/addrgen_checker.sv
tests/tb_vlsu_addrgen.sv

/* Bender.yml */
package:
  name: vlsu_addrgen

sources:
  - src/vlsu_pkg.sv
  - src/axi_ax_pkg.sv
  - src/addrgen_ctrl.sv
  - src/burst_planner.sv
  - src/ax_issuer.sv
  - src/lsu_req_queue.sv
  - src/vlsu_addrgen.sv
  - target: test
    files:
      - tests/addrgen_checker.sv
      - tests/tb_vlsu_addrgen.sv

/* tests/tb_vlsu_addrgen.sv */
/*
 * Testbench top for the vector address generator.
 * Requests and expected results come from tests/addrgen_stimulus.hex,
 * opened relative to the project root. Inputs change on the falling edge.
 * A lsu_hold of zero keeps the hold count left over from the previous line.
 */
`timescale 1ns/1ns

module tb_vlsu_addrgen import vlsu_pkg::*; import axi_ax_pkg::*; ();

  localparam int unsigned ClkPeriod     = 20;
  localparam int unsigned StimDepth     = 16;
  localparam int unsigned CyclesPerTest = 300;
  localparam logic [31:0] LfsrSeed      = 32'h1da9_7e6b;
  localparam logic [31:0] LfsrTaps      = 32'h8020_0003;

  // One stimulus line with fields in file order
  typedef struct packed {
    logic [3:0]  mode;
    logic [7:0]  st_pend;
    logic [7:0]  lsu_hold;
    addr_t       addr;
    vlen_t       len;
    logic [31:0] stride;
    logic [3:0]  ctrl;
    logic [3:0]  exp_error;
    logic [15:0] exp_count;
    addr_t       exp_first_addr;
    logic [7:0]  exp_first_len;
  } stim_t;

  logic     clk_i, rst_ni;
  mem_req_t req_i;
  logic     req_valid_i, req_ack_o, req_error_o, core_st_pending_i;
  axi_ax_t  ar_o, aw_o;
  logic     ar_valid_o, ar_ready_i, aw_valid_o, aw_ready_i;
  lsu_req_t lsu_req_o;
  logic     lsu_req_valid_o, lsu_req_ready_i;

  logic [$bits(stim_t)-1:0] stim_mem [StimDepth];
  stim_t       cur;
  int          num_tests, test_idx, pend_left, hold_left;
  int          value_errors, tests_passed, tests_failed, outstanding;
  logic [31:0] lfsr;
  logic        any_fail;

  vlsu_addrgen vlsu_addrgen_inst (.*);

  addrgen_checker addrgen_checker_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .req_ack_i        (req_ack_o),
    .req_error_i      (req_error_o),
    .core_st_pending_i(core_st_pending_i),
    .ar_i             (ar_o),
    .ar_valid_i       (ar_valid_o),
    .ar_ready_i       (ar_ready_i),
    .aw_i             (aw_o),
    .aw_valid_i       (aw_valid_o),
    .aw_ready_i       (aw_ready_i),
    .lsu_req_i        (lsu_req_o),
    .lsu_req_valid_i  (lsu_req_valid_o),
    .lsu_req_ready_i  (lsu_req_ready_i),
    .test_idx_i       (test_idx),
    .exp_error_i      (cur.exp_error[0]),
    .exp_count_i      (cur.exp_count),
    .exp_first_addr_i (cur.exp_first_addr),
    .exp_first_len_i  (cur.exp_first_len),
    .value_errors_o   (value_errors),
    .tests_passed_o   (tests_passed),
    .tests_failed_o   (tests_failed),
    .outstanding_o    (outstanding)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random back-pressure
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) return (state >> 1) ^ LfsrTaps;
    return state >> 1;
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  // Drives the ready lines and the store-pending flag once per falling edge
  task automatic drive_cycle();
    if (cur.mode == 4'd1) begin
      take_bit(ar_ready_i);
      take_bit(aw_ready_i);
      take_bit(lsu_req_ready_i);
    end else begin
      ar_ready_i      = 1'b1;
      aw_ready_i      = 1'b1;
      lsu_req_ready_i = 1'b1;
    end
    if (hold_left > 0) begin
      lsu_req_ready_i = 1'b0;
      hold_left--;
    end
    core_st_pending_i = (pend_left > 0);
    if (pend_left > 0) pend_left--;
  endtask

  // Starts on a falling edge and returns on the falling edge after ack
  task automatic run_test(input int idx);
    logic acked;
    cur       = stim_t'(stim_mem[idx]);
    test_idx  = idx;
    pend_left = cur.st_pend;
    if (cur.lsu_hold != 0) hold_left = cur.lsu_hold;
    req_i = '{addr: cur.addr, len: cur.len, stride: cur.stride,
              vew: vew_e'(cur.ctrl[3:2]), is_load: cur.ctrl[1],
              unit_stride: cur.ctrl[0]};
    req_valid_i = 1'b1;
    drive_cycle();
    forever begin
      @(posedge clk_i);
      acked = req_ack_o;
      @(negedge clk_i);
      if (acked) break;
      drive_cycle();
    end
    req_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    rst_ni            = 1'b0;
    req_i             = '0;
    req_valid_i       = 1'b0;
    core_st_pending_i = 1'b0;
    ar_ready_i        = 1'b1;
    aw_ready_i        = 1'b1;
    lsu_req_ready_i   = 1'b1;
    cur               = '0;
    test_idx          = 0;
    pend_left         = 0;
    hold_left         = 0;
    lfsr              = LfsrSeed;
    any_fail          = 1'b0;
    // All-ones marks lines past the end of the file
    foreach (stim_mem[i]) stim_mem[i] = '1;
    $readmemh("tests/addrgen_stimulus.hex", stim_mem);
    num_tests = 0;
    while (num_tests < StimDepth && stim_mem[num_tests] != '1) num_tests++;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int t = 0; t < num_tests; t++) run_test(t);
    // Drain the queue so every entry gets compared
    drive_cycle();
    while (lsu_req_valid_o) begin
      @(negedge clk_i);
      drive_cycle();
    end
    if (num_tests == 0) begin
      $display("no stimulus lines were read");
      any_fail = 1'b1;
    end
    if (outstanding != 0) begin
      $display("%0d load/store queue entries never reached the units", outstanding);
      any_fail = 1'b1;
    end
    if (value_errors != 0 || tests_failed != 0 || tests_passed != num_tests) any_fail = 1'b1;
    $display("tests run %0d, passed %0d, failed %0d, value errors %0d",
             num_tests, tests_passed, tests_failed, value_errors);
    if (any_fail) begin
      $display(">>> FAIL");
    end else begin
      $display(">>> PASS");
    end
    $finish;
  end

  initial begin
    #1;
    repeat ((num_tests + 1) * CyclesPerTest) @(posedge clk_i);
    $display("timeout: the run hung and did not finish within %0d cycles",
             (num_tests + 1) * CyclesPerTest);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* tests/addrgen_checker.sv */
/*
 * Watches the address generator ports and checks every AX handshake,
 * every load/store queue pop and every ack. Expected first transfer and
 * counts come from the testbench; burst and stride rules are checked here.
 */
`timescale 1ns/1ns

module addrgen_checker import vlsu_pkg::*; import axi_ax_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  mem_req_t    req_i,
  input  logic        req_ack_i,
  input  logic        req_error_i,
  input  logic        core_st_pending_i,
  input  axi_ax_t     ar_i,
  input  logic        ar_valid_i,
  input  logic        ar_ready_i,
  input  axi_ax_t     aw_i,
  input  logic        aw_valid_i,
  input  logic        aw_ready_i,
  input  lsu_req_t    lsu_req_i,
  input  logic        lsu_req_valid_i,
  input  logic        lsu_req_ready_i,
  input  int          test_idx_i,
  input  logic        exp_error_i,
  input  logic [15:0] exp_count_i,
  input  addr_t       exp_first_addr_i,
  input  logic [7:0]  exp_first_len_i,
  output int          value_errors_o,
  output int          tests_passed_o,
  output int          tests_failed_o,
  output int          outstanding_o
);

  lsu_req_t expected_q [$];
  int       ax_count;
  int       errors_at_start;
  addr_t    prev_end;

  task automatic report_error(input string msg);
    $display("error %0t: test %0d %s", $time, test_idx_i, msg);
    value_errors_o++;
  endtask

  // One AX handshake, is_load tells which channel carried it
  task automatic check_ax(input axi_ax_t ax, input logic is_load);
    addr_t    burst_end;
    addr_t    want_addr;
    lsu_req_t entry;
    burst_end = (ax.addr & ~addr_t'(BusBytes - 1))
              + (addr_t'(ax.len) + addr_t'(1)) * addr_t'(BusBytes) - addr_t'(1);
    if (is_load != req_i.is_load) report_error("transfer on the wrong AX channel");
    if (core_st_pending_i) report_error("AX handshake while a scalar store is pending");
    if (!is_load && lsu_req_valid_i && lsu_req_i.is_load)
      report_error("AW handshake while a load heads the queue");
    if (ax.burst != BurstIncr || ax.cache != CacheModifiable)
      report_error($sformatf("burst %b cache %b", ax.burst, ax.cache));
    if (ax_count == 0 && (ax.addr != exp_first_addr_i || ax.len != exp_first_len_i))
      report_error($sformatf("first AX addr %h len %0d, expected addr %h len %0d",
                             ax.addr, ax.len, exp_first_addr_i, exp_first_len_i));
    if (req_i.unit_stride) begin
      if (ax.size != 3'(BusSizeLog)) report_error($sformatf("burst size %0d", ax.size));
      if (ax_count != 0 && ax.addr != prev_end + addr_t'(1))
        report_error($sformatf("burst at %h, expected %h", ax.addr, prev_end + 1));
      // Start and last byte must share one 4 KiB page
      if (burst_end[AddrWidth-1:PageOffsetBits] != ax.addr[AddrWidth-1:PageOffsetBits])
        report_error($sformatf("burst at %h len %0d crosses a page", ax.addr, ax.len));
      prev_end = burst_end;
    end else begin
      want_addr = req_i.addr + addr_t'(ax_count) * req_i.stride;
      if (ax.len != 8'd0 || ax.size != {1'b0, req_i.vew} || ax.addr != want_addr)
        report_error($sformatf("beat addr %h len %0d size %0d, expected %h len 0 size %0d",
                               ax.addr, ax.len, ax.size, want_addr, req_i.vew));
    end
    entry = '{addr: ax.addr, len: ax.len, size: ax.size, is_load: is_load};
    expected_q.push_back(entry);
    ax_count++;
  endtask

  task automatic check_pop();
    lsu_req_t want;
    if (expected_q.size() == 0) begin
      report_error("queue entry with no matching AX handshake");
    end else begin
      want = expected_q.pop_front();
      if (lsu_req_i != want)
        report_error($sformatf("queue entry %h, expected %h", lsu_req_i, want));
    end
  endtask

  task automatic finish_test();
    if (req_error_i != exp_error_i)
      report_error($sformatf("req_error_o %b, expected %b", req_error_i, exp_error_i));
    if (ax_count != int'(exp_count_i))
      report_error($sformatf("%0d AX transfers, expected %0d", ax_count, exp_count_i));
    if (value_errors_o == errors_at_start) begin
      tests_passed_o++;
      $display("test %0d: pass, %0d AX transfers", test_idx_i, ax_count);
    end else begin
      tests_failed_o++;
      $display("test %0d: failed, %0d errors", test_idx_i, value_errors_o - errors_at_start);
    end
    errors_at_start = value_errors_o;
    ax_count        = 0;
  endtask

  // Pops first, an entry is never popped in its own push cycle
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (lsu_req_valid_i && lsu_req_ready_i) check_pop();
      if (ar_valid_i && ar_ready_i) check_ax(ar_i, 1'b1);
      if (aw_valid_i && aw_ready_i) check_ax(aw_i, 1'b0);
      if (req_error_i && !req_ack_i) report_error("req_error_o high without ack");
      if (req_ack_i) finish_test();
      outstanding_o = expected_q.size();
    end
  end

endmodule

/* src/vlsu_addrgen.sv */
/*
 * Vector load/store address generator, one request at a time.
 * Outputs AR/AW with valid/ready and a queue of issued transactions
 * for the load/store units.
 */
`timescale 1ns/1ns

module vlsu_addrgen import vlsu_pkg::*; import axi_ax_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Sequencer
  input  mem_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ack_o,
  output logic     req_error_o,
  input  logic     core_st_pending_i,
  // AXI address channels
  output axi_ax_t  ar_o,
  output logic     ar_valid_o,
  input  logic     ar_ready_i,
  output axi_ax_t  aw_o,
  output logic     aw_valid_o,
  input  logic     aw_ready_i,
  // Load/store units
  output lsu_req_t lsu_req_o,
  output logic     lsu_req_valid_o,
  input  logic     lsu_req_ready_i
);

  mem_req_t plan_req;
  axi_ax_t  next_ax;
  lsu_req_t lsu_entry;
  logic     plan_load, issue_en, done, fire, next_is_load;
  logic     q_full, q_empty, q_head_is_load;

  addrgen_ctrl addrgen_ctrl_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .req_valid_i      (req_valid_i),
    .core_st_pending_i(core_st_pending_i),
    .done_i           (done),
    .fire_i           (fire),
    .req_ack_o        (req_ack_o),
    .req_error_o      (req_error_o),
    .plan_load_o      (plan_load),
    .plan_req_o       (plan_req),
    .issue_en_o       (issue_en)
  );

  burst_planner burst_planner_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .plan_load_i   (plan_load),
    .plan_req_i    (plan_req),
    .fire_i        (fire),
    .next_ax_o     (next_ax),
    .next_is_load_o(next_is_load),
    .done_o        (done)
  );

  ax_issuer ax_issuer_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_en_i      (issue_en),
    .next_ax_i       (next_ax),
    .next_is_load_i  (next_is_load),
    .q_full_i        (q_full),
    .q_empty_i       (q_empty),
    .q_head_is_load_i(q_head_is_load),
    .ar_o            (ar_o),
    .ar_valid_o      (ar_valid_o),
    .ar_ready_i      (ar_ready_i),
    .aw_o            (aw_o),
    .aw_valid_o      (aw_valid_o),
    .aw_ready_i      (aw_ready_i),
    .fire_o          (fire),
    .lsu_entry_o     (lsu_entry)
  );

  lsu_req_queue lsu_req_queue_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (fire),
    .entry_i        (lsu_entry),
    .full_o         (q_full),
    .empty_o        (q_empty),
    .head_is_load_o (q_head_is_load),
    .lsu_req_o      (lsu_req_o),
    .lsu_req_valid_o(lsu_req_valid_o),
    .lsu_req_ready_i(lsu_req_ready_i)
  );

endmodule

/* src/lsu_req_queue.sv */
/*
 * Two-entry FIFO of issued transactions for the load/store units.
 * The head is visible the cycle after its push. Pushing while full is
 * not allowed; the issuer holds off instead.
 */
`timescale 1ns/1ns

module lsu_req_queue import axi_ax_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  lsu_req_t entry_i,
  output logic     full_o,
  output logic     empty_o,
  output logic     head_is_load_o,
  output lsu_req_t lsu_req_o,
  output logic     lsu_req_valid_o,
  input  logic     lsu_req_ready_i
);

  lsu_req_t   mem_q [2];
  logic       wr_ptr_q, rd_ptr_q;
  logic [1:0] count_q;
  logic       pop;

  assign full_o          = (count_q == 2'd2);
  assign empty_o         = (count_q == 2'd0);
  assign lsu_req_valid_o = !empty_o;
  assign lsu_req_o       = mem_q[rd_ptr_q];
  assign head_is_load_o  = mem_q[rd_ptr_q].is_load;
  assign pop             = lsu_req_valid_o && lsu_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push_i) wr_ptr_q <= !wr_ptr_q;
      if (pop) rd_ptr_q <= !rd_ptr_q;
      // Simultaneous push and pop keeps the count
      if (push_i && !pop) count_q <= count_q + 2'd1;
      else if (pop && !push_i) count_q <= count_q - 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= entry_i;
  end

  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

endmodule

/* src/ax_issuer.sv */
/*
 * Drives AR or AW from the planner's next transaction.
 * Valid is registered, so each transaction costs at least two cycles.
 * A direction change waits for the load/store queue to drain.
 */
`timescale 1ns/1ns

module ax_issuer import axi_ax_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     issue_en_i,
  input  axi_ax_t  next_ax_i,
  input  logic     next_is_load_i,
  input  logic     q_full_i,
  input  logic     q_empty_i,
  input  logic     q_head_is_load_i,
  output axi_ax_t  ar_o,
  output logic     ar_valid_o,
  input  logic     ar_ready_i,
  output axi_ax_t  aw_o,
  output logic     aw_valid_o,
  input  logic     aw_ready_i,
  output logic     fire_o,
  output lsu_req_t lsu_entry_o
);

  logic valid_q;
  logic ax_ready;
  logic order_ok;

  // Queue must be empty or already hold this direction at its head
  assign order_ok = q_empty_i || (q_head_is_load_i == next_is_load_i);
  assign ax_ready = next_is_load_i ? ar_ready_i : aw_ready_i;

  assign ar_o       = next_is_load_i ? next_ax_i : '0;
  assign aw_o       = next_is_load_i ? '0 : next_ax_i;
  assign ar_valid_o = valid_q && next_is_load_i;
  assign aw_valid_o = valid_q && !next_is_load_i;
  assign fire_o     = valid_q && ax_ready;

  assign lsu_entry_o.addr    = next_ax_i.addr;
  assign lsu_entry_o.len     = next_ax_i.len;
  assign lsu_entry_o.size    = next_ax_i.size;
  assign lsu_entry_o.is_load = next_is_load_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (valid_q) begin
      valid_q <= !ax_ready;
    end else begin
      valid_q <= issue_en_i && !q_full_i && order_ok;
    end
  end

  // Planner must not move under a pending transaction
  ax_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_q && !ax_ready) |=> (valid_q && $stable(next_ax_i) && $stable(next_is_load_i)));

endmodule

/* src/burst_planner.sv */
/*
 * Splits a request into AX transactions.
 * Unit-stride bursts use the full bus, are capped at 256 beats and stay
 * inside one 4 KiB page. Strided requests give one beat per element.
 * plan_req_i must hold steady while the plan runs.
 */
`timescale 1ns/1ns

module burst_planner import vlsu_pkg::*; import axi_ax_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     plan_load_i,
  input  mem_req_t plan_req_i,
  input  logic     fire_i,
  output axi_ax_t  next_ax_o,
  output logic     next_is_load_o,
  output logic     done_o
);

  addr_t cur_addr_q, cur_addr_d;
  vlen_t remaining_q, rem_after;

  addr_t aligned_start, aligned_end, max_bytes;
  addr_t rem_bytes, burst_bytes, last_byte;
  addr_t beats_m1, consumed_elems;

  ////////////////////////////////////////////////////////////////////////////
  // Unit-stride burst bounds
  ////////////////////////////////////////////////////////////////////////////

  assign max_bytes     = addr_t'(MaxBurstBeats * BusBytes);
  assign aligned_start = {cur_addr_q[AddrWidth-1:BusSizeLog], {BusSizeLog{1'b0}}};
  assign rem_bytes     = addr_t'(remaining_q) << plan_req_i.vew;
  assign burst_bytes   = (rem_bytes > max_bytes) ? max_bytes : rem_bytes;
  assign last_byte     = cur_addr_q + burst_bytes - addr_t'(1);

  always_comb begin
    aligned_end = {last_byte[AddrWidth-1:BusSizeLog], {BusSizeLog{1'b1}}};
    // A misaligned start could spill into a 257th bus word
    if ((aligned_end - aligned_start) > (max_bytes - addr_t'(1)))
      aligned_end = aligned_start + max_bytes - addr_t'(1);
    // Clip to the end of the starting page
    if (aligned_end[AddrWidth-1:PageOffsetBits] != aligned_start[AddrWidth-1:PageOffsetBits])
      aligned_end = {aligned_start[AddrWidth-1:PageOffsetBits], {PageOffsetBits{1'b1}}};
  end

  assign beats_m1       = (aligned_end - aligned_start) >> BusSizeLog;
  assign consumed_elems = (aligned_end - cur_addr_q + addr_t'(1)) >> plan_req_i.vew;

  ////////////////////////////////////////////////////////////////////////////
  // Next transaction and step
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_ax_o.addr  = cur_addr_q;
    next_ax_o.burst = BurstIncr;
    next_ax_o.cache = CacheModifiable;
    if (plan_req_i.unit_stride) begin
      next_ax_o.len  = beats_m1[7:0];
      next_ax_o.size = 3'(BusSizeLog);
      cur_addr_d     = aligned_end + addr_t'(1);
      // Last burst may cover bytes past the final element
      if (addr_t'(remaining_q) > consumed_elems)
        rem_after = remaining_q - vlen_t'(consumed_elems);
      else
        rem_after = '0;
    end else begin
      next_ax_o.len  = 8'd0;
      next_ax_o.size = {1'b0, plan_req_i.vew};
      cur_addr_d     = cur_addr_q + plan_req_i.stride;
      rem_after      = remaining_q - vlen_t'(1);
    end
  end

  assign next_is_load_o = plan_req_i.is_load;
  assign done_o         = (rem_after == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remaining_q <= '0;
    end else if (plan_load_i) begin
      remaining_q <= plan_req_i.len;
    end else if (fire_i) begin
      remaining_q <= rem_after;
    end
  end

  always_ff @(posedge clk_i) begin
    if (plan_load_i) cur_addr_q <= plan_req_i.addr;
    else if (fire_i) cur_addr_q <= cur_addr_d;
  end

  // Every issued transaction still has elements left to cover
  burst_fits: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fire_i |-> (remaining_q != '0) &&
               (!plan_req_i.unit_stride || beats_m1 < addr_t'(MaxBurstBeats)));

endmodule

/* src/addrgen_ctrl.sv */
/*
 * Request FSM of the address generator.
 * The request must stay stable on req_i until ack. Pending scalar stores
 * are only sampled before issue starts.
 */
`timescale 1ns/1ns

module addrgen_ctrl import vlsu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t req_i,
  input  logic     req_valid_i,
  input  logic     core_st_pending_i,
  input  logic     done_i,
  input  logic     fire_i,
  output logic     req_ack_o,
  output logic     req_error_o,
  output logic     plan_load_o,
  output mem_req_t plan_req_o,
  output logic     issue_en_o
);

  typedef enum logic [1:0] {IDLE, CHECK, WAIT_STORE, ISSUE} state_e;

  state_e   state_q, state_d;
  mem_req_t req_q;
  addr_t    align_mask;
  logic     misaligned;

  // Low vew bits of the base address must be zero
  assign align_mask = (addr_t'(1) << req_q.vew) - addr_t'(1);
  assign misaligned = (req_q.addr & align_mask) != '0;

  assign plan_req_o = req_q;
  assign issue_en_o = (state_q == ISSUE);

  always_comb begin
    state_d     = state_q;
    req_ack_o   = 1'b0;
    req_error_o = 1'b0;
    plan_load_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (req_valid_i) state_d = CHECK;
      end
      CHECK: begin
        if (misaligned) begin
          req_ack_o   = 1'b1;
          req_error_o = 1'b1;
          state_d     = IDLE;
        end else begin
          plan_load_o = 1'b1;
          state_d     = WAIT_STORE;
        end
      end
      WAIT_STORE: begin
        if (!core_st_pending_i) state_d = ISSUE;
      end
      ISSUE: begin
        // Last transaction of the request leaves this cycle
        if (fire_i && done_i) begin
          req_ack_o = 1'b1;
          state_d   = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_valid_i) req_q <= req_i;
  end

  // No transaction of the finished request leaves after its ack
  ack_stops_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_ack_o |=> (!issue_en_o && !fire_i));

endmodule

/* src/axi_ax_pkg.sv */
/*
 * AXI address channel constants and structs.
 * The data bus is fixed at 8 bytes; only INCR bursts are generated.
 */
package axi_ax_pkg;

  localparam int unsigned BusBytes       = 8;
  localparam int unsigned BusSizeLog     = 3;
  localparam int unsigned MaxBurstBeats  = 256;
  localparam int unsigned PageOffsetBits = 12;

  localparam logic [1:0] BurstIncr       = 2'b01;
  localparam logic [3:0] CacheModifiable = 4'b0010;

  // AR or AW channel payload
  typedef struct packed {
    vlsu_pkg::addr_t addr;
    logic [7:0]      len;
    logic [2:0]      size;
    logic [1:0]      burst;
    logic [3:0]      cache;
  } axi_ax_t;

  // Entry handed to the load/store units
  typedef struct packed {
    vlsu_pkg::addr_t addr;
    logic [7:0]      len;
    logic [2:0]      size;
    logic            is_load;
  } lsu_req_t;

endpackage

/* src/vlsu_pkg.sv */
/*
 * Vector-side types shared by the address generator.
 * Element width is encoded as log2 of the element byte count.
 * A request with len of zero is not supported and must not be sent.
 */
package vlsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned VlenWidth = 16;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [VlenWidth-1:0] vlen_t;

  // Element width, value is log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer request
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    addr_t       addr;
    vlen_t       len;
    logic [31:0] stride;
    vew_e        vew;
    logic        is_load;
    logic        unit_stride;
  } mem_req_t;

endpackage
